//--- include/tetris_cfg.svh
// tetris playfield configuration
// field geometry, spawn point, SNES button bits and code widths
`ifndef TETRIS_CFG_SVH
`define TETRIS_CFG_SVH

// ==============================
// field geometry
// ==============================
`define TETRIS_FIELD_W      12      // columns, walls included
`define TETRIS_FIELD_H      22      // rows, bottom wall included
`define TETRIS_FIELD_CELLS  264     // also the idle scan address

// new piece placement
`define TETRIS_SPAWN_X      6
`define TETRIS_SPAWN_Y      1
`define TETRIS_SPAWN_ANGLE  0

// ==============================
// SNES state word bits
// ==============================
`define TETRIS_BTN_ROT_R    6
`define TETRIS_BTN_RIGHT    7
`define TETRIS_BTN_LEFT     8
`define TETRIS_BTN_DOWN     9
`define TETRIS_BTN_SELECT   12
`define TETRIS_BTN_FIX      13
`define TETRIS_BTN_ROT_L    14

`define TETRIS_CELL_W       4       // cell code bits
`define TETRIS_ADDR_W       9       // field address bits

`endif

//--- source/tetris_pkg.sv
// tetris playfield types
// cell codes, piece state types and the per-angle cell offsets
`include "tetris_cfg.svh"

package tetris_pkg;

    typedef enum logic [`TETRIS_CELL_W-1:0] {
        EMPTY = 4'd0,
        WALL  = 4'd1,
        I     = 4'd2,
        O     = 4'd3,
        S     = 4'd4,
        Z     = 4'd5,
        J     = 4'd6,
        L     = 4'd7,
        T     = 4'd8
    } cell_t;

    typedef logic [1:0]                 angle_t;        // 0..3, right turn adds 1
    typedef logic [3:0]                 pos_x_t;
    typedef logic [4:0]                 pos_y_t;
    typedef logic [`TETRIS_ADDR_W-1:0]  field_addr_t;   // row * 12 + column
    typedef logic signed [2:0]          offset_t;

    // [kind - I][angle][cell][dx, dy] around the piece position
    localparam offset_t PIECE_OFFSETS [7][4][4][2] = '{
        '{'{'{ 0, 0}, '{-1, 0}, '{ 1, 0}, '{ 2, 0}},     // I
          '{'{ 1,-1}, '{ 1, 0}, '{ 1, 1}, '{ 1, 2}},
          '{'{ 0, 1}, '{-1, 1}, '{ 1, 1}, '{ 2, 1}},
          '{'{ 0,-1}, '{ 0, 0}, '{ 0, 1}, '{ 0, 2}}},
        '{'{'{ 0, 0}, '{ 0,-1}, '{-1, 0}, '{-1,-1}},     // O
          '{'{ 0, 0}, '{ 0,-1}, '{-1, 0}, '{-1,-1}},
          '{'{ 0, 0}, '{ 0,-1}, '{-1, 0}, '{-1,-1}},
          '{'{ 0, 0}, '{ 0,-1}, '{-1, 0}, '{-1,-1}}},
        '{'{'{ 0, 0}, '{-1, 0}, '{ 0,-1}, '{ 1,-1}},     // S
          '{'{ 0, 0}, '{ 0,-1}, '{ 1, 0}, '{ 1, 1}},
          '{'{ 0, 0}, '{ 1, 0}, '{ 0, 1}, '{-1, 1}},
          '{'{ 0, 0}, '{-1, 0}, '{-1,-1}, '{ 0, 1}}},
        '{'{'{ 0, 0}, '{ 0,-1}, '{-1,-1}, '{ 1, 0}},     // Z
          '{'{ 0, 0}, '{ 1, 0}, '{ 1,-1}, '{ 0, 1}},
          '{'{ 0, 0}, '{-1, 0}, '{ 0, 1}, '{ 1, 1}},
          '{'{ 0, 0}, '{ 0,-1}, '{-1, 0}, '{-1, 1}}},
        '{'{'{ 0, 0}, '{-1, 0}, '{-1,-1}, '{ 1, 0}},     // J
          '{'{ 0, 0}, '{ 0,-1}, '{ 1,-1}, '{ 0, 1}},
          '{'{ 0, 0}, '{-1, 0}, '{ 1, 0}, '{ 1, 1}},
          '{'{ 0, 0}, '{ 0,-1}, '{ 0, 1}, '{-1, 1}}},
        '{'{'{ 0, 0}, '{-1, 0}, '{ 1,-1}, '{ 1, 0}},     // L
          '{'{ 0, 0}, '{ 0,-1}, '{ 0, 1}, '{ 1, 1}},
          '{'{ 0, 0}, '{-1, 0}, '{-1, 1}, '{ 1, 0}},
          '{'{ 0, 0}, '{ 0,-1}, '{-1,-1}, '{ 0, 1}}},
        '{'{'{ 0, 0}, '{-1, 0}, '{ 1, 0}, '{ 0,-1}},     // T
          '{'{ 0, 0}, '{ 0,-1}, '{ 1, 0}, '{ 0, 1}},
          '{'{ 0, 0}, '{-1, 0}, '{ 1, 0}, '{ 0, 1}},
          '{'{ 0, 0}, '{-1, 0}, '{ 0,-1}, '{ 0, 1}}}
    };

endpackage

//--- source/piece_control.sv
// active piece control
// button edges move and rotate the piece, raise clear and fix requests
`timescale 1ns/100ps
`include "tetris_cfg.svh"

module piece_control (
    input   logic                   i_clk,
    input   logic                   i_res_n,
    input   logic   [14:0]          i_snes_state,
    input   logic                   i_fix_busy,     // field_writer is fixing
    input   logic                   i_fix_done,     // fix finished, spawn
    output  tetris_pkg::cell_t      o_kind,
    output  tetris_pkg::angle_t     o_angle,
    output  tetris_pkg::pos_x_t     o_pos_x,
    output  tetris_pkg::pos_y_t     o_pos_y,
    output  logic                   o_fix_req,
    output  logic                   o_clear_req
);
    import tetris_pkg::*;

    logic   [14:0]  r_btn_old;
    logic   [14:0]  w_press;
    cell_t          r_next_kind;

    assign w_press = i_snes_state & ~r_btn_old;     // rising edges only

    // ==============================
    // request pulses
    // ==============================
    always_ff @(posedge i_clk or negedge i_res_n) begin
        if (!i_res_n) begin
            r_btn_old   <= '0;
            o_fix_req   <= 1'b0;
            o_clear_req <= 1'b0;
        end else begin
            r_btn_old   <= i_snes_state;
            o_fix_req   <= w_press[`TETRIS_BTN_FIX];
            o_clear_req <= w_press[`TETRIS_BTN_SELECT];
        end
    end

    // ==============================
    // piece state
    // ==============================
    always_ff @(posedge i_clk or negedge i_res_n) begin
        if (!i_res_n) begin
            o_kind      <= I;
            r_next_kind <= O;
            o_angle     <= angle_t'(`TETRIS_SPAWN_ANGLE);
            o_pos_x     <= pos_x_t'(`TETRIS_SPAWN_X);
            o_pos_y     <= pos_y_t'(`TETRIS_SPAWN_Y);
        end else if (i_fix_done) begin
            // new piece at the spawn point
            o_kind      <= r_next_kind;
            r_next_kind <= (r_next_kind == T) ? I : cell_t'(r_next_kind + 4'd1);
            o_angle     <= angle_t'(`TETRIS_SPAWN_ANGLE);
            o_pos_x     <= pos_x_t'(`TETRIS_SPAWN_X);
            o_pos_y     <= pos_y_t'(`TETRIS_SPAWN_Y);
        end else if (!i_fix_busy) begin
            if (w_press[`TETRIS_BTN_ROT_R]) begin
                o_angle <= o_angle + 2'd1;
            end else if (w_press[`TETRIS_BTN_ROT_L]) begin
                o_angle <= o_angle - 2'd1;
            end else if (w_press[`TETRIS_BTN_DOWN]) begin
                o_pos_y <= o_pos_y + 5'd1;
            end else if (w_press[`TETRIS_BTN_LEFT]) begin
                o_pos_x <= o_pos_x - 4'd1;      // no wall check, wraps
            end else if (w_press[`TETRIS_BTN_RIGHT]) begin
                o_pos_x <= o_pos_x + 4'd1;
            end
        end
    end

    // spawn counter must only ever hand out real pieces
    a_kind_is_piece: assert property (@(posedge i_clk) disable iff (!i_res_n)
        o_kind inside {I, O, S, Z, J, L, T});

endmodule

//--- source/piece_shape.sv
// piece footprint test
// flags the scanned cell when it lies under one of the active piece cells
`timescale 1ns/100ps

module piece_shape (
    input   tetris_pkg::pos_x_t     i_pos_x,        // scan column
    input   tetris_pkg::pos_y_t     i_pos_y,        // scan row
    input   tetris_pkg::cell_t      i_kind,
    input   tetris_pkg::angle_t     i_angle,
    input   tetris_pkg::pos_x_t     i_piece_x,
    input   tetris_pkg::pos_y_t     i_piece_y,
    output  logic                   o_covered
);
    import tetris_pkg::*;

    logic           w_kind_ok;
    logic   [2:0]   w_kind_idx;

    assign w_kind_ok  = (i_kind >= I) && (i_kind <= T);
    assign w_kind_idx = w_kind_ok ? 3'(i_kind - I) : 3'd0;     // table row

    // four cells per shape, sums wrap like the position registers
    always_comb begin
        o_covered = 1'b0;
        for (int n = 0; n < 4; n++) begin
            if (i_pos_x == i_piece_x + 4'(PIECE_OFFSETS[w_kind_idx][i_angle][n][0]) &&
                i_pos_y == i_piece_y + 5'(PIECE_OFFSETS[w_kind_idx][i_angle][n][1])) begin
                o_covered = w_kind_ok;
            end
        end
    end

endmodule

//--- source/field_writer.sv
// field write sequencer
// runs the wall rebuild and the piece fix, one of them per frame
`timescale 1ns/100ps
`include "tetris_cfg.svh"

module field_writer (
    input   logic                       i_clk,
    input   logic                       i_res_n,
    input   logic                       i_fix_req,
    input   logic                       i_clear_req,
    input   tetris_pkg::field_addr_t    i_vram_addr,
    input   logic                       i_covered,
    input   tetris_pkg::cell_t          i_kind,
    output  logic                       o_wr_en,
    output  tetris_pkg::field_addr_t    o_wr_addr,
    output  tetris_pkg::cell_t          o_wr_data,
    output  logic                       o_fix_busy,
    output  logic                       o_fix_done
);
    import tetris_pkg::*;

    logic           r_clr_pend;
    logic           r_fix_pend;
    logic           r_clr_busy;
    logic           r_fix_busy;
    pos_x_t         r_clr_x;
    pos_y_t         r_clr_y;
    logic           r_fix_wen;
    field_addr_t    r_fix_addr;
    cell_t          r_fix_data;
    field_addr_t    w_clr_addr;
    cell_t          w_clr_data;
    logic           w_frame_start;
    logic           w_clr_start;
    logic           w_fix_start;

    // requests only start at the top of a frame
    assign w_frame_start = (i_vram_addr == '0) && !r_clr_busy && !r_fix_busy;
    assign w_clr_start   = w_frame_start && r_clr_pend;
    assign w_fix_start   = w_frame_start && r_fix_pend && !r_clr_pend;  // clear wins

    always_ff @(posedge i_clk or negedge i_res_n) begin
        if (!i_res_n) begin
            r_clr_pend <= 1'b0;
            r_fix_pend <= 1'b0;
        end else begin
            if (w_clr_start) begin
                r_clr_pend <= 1'b0;
            end else if (i_clear_req) begin
                r_clr_pend <= 1'b1;
            end
            if (w_fix_start) begin
                r_fix_pend <= 1'b0;
            end else if (i_fix_req) begin
                r_fix_pend <= 1'b1;
            end
        end
    end

    // ==============================
    // wall rebuild, own counter
    // ==============================
    assign w_clr_addr = field_addr_t'(r_clr_y) * field_addr_t'(`TETRIS_FIELD_W) +
                        field_addr_t'(r_clr_x);
    assign w_clr_data = (r_clr_y == pos_y_t'(`TETRIS_FIELD_H - 1) || r_clr_x == 4'd0 ||
                         r_clr_x == pos_x_t'(`TETRIS_FIELD_W - 1) ||
                         (r_clr_y == 5'd0 && r_clr_x inside {4'd1, 4'd2,
                             pos_x_t'(`TETRIS_FIELD_W - 3), pos_x_t'(`TETRIS_FIELD_W - 2)}))
                        ? WALL : EMPTY;

    always_ff @(posedge i_clk or negedge i_res_n) begin
        if (!i_res_n) begin
            r_clr_busy <= 1'b0;
            r_clr_x    <= '0;
            r_clr_y    <= '0;
        end else if (w_clr_start) begin
            r_clr_busy <= 1'b1;
            r_clr_x    <= '0;
            r_clr_y    <= '0;
        end else if (r_clr_busy) begin
            if (w_clr_addr == field_addr_t'(`TETRIS_FIELD_CELLS - 1)) begin
                r_clr_busy <= 1'b0;     // last cell written this clock
            end
            if (r_clr_x == pos_x_t'(`TETRIS_FIELD_W - 1)) begin
                r_clr_x <= '0;
                r_clr_y <= r_clr_y + 5'd1;
            end else begin
                r_clr_x <= r_clr_x + 4'd1;
            end
        end
    end

    // ==============================
    // piece fix, follows the scan
    // ==============================
    always_ff @(posedge i_clk or negedge i_res_n) begin
        if (!i_res_n) begin
            r_fix_busy <= 1'b0;
            r_fix_wen  <= 1'b0;
            o_fix_done <= 1'b0;
        end else begin
            o_fix_done <= 1'b0;
            r_fix_wen  <= 1'b0;
            if (w_fix_start) begin
                r_fix_busy <= 1'b1;
            end else if (r_fix_busy && i_vram_addr == field_addr_t'(`TETRIS_FIELD_CELLS)) begin
                r_fix_busy <= 1'b0;
                o_fix_done <= 1'b1;
            end
            if (w_fix_start || r_fix_busy) begin
                r_fix_wen <= i_covered && (i_vram_addr < field_addr_t'(`TETRIS_FIELD_CELLS));
            end
        end
    end

    always_ff @(posedge i_clk) begin
        r_fix_addr <= i_vram_addr;
        r_fix_data <= i_kind;
    end

    assign o_wr_en    = r_clr_busy || r_fix_wen;
    assign o_wr_addr  = r_clr_busy ? w_clr_addr : r_fix_addr;
    assign o_wr_data  = r_clr_busy ? w_clr_data : r_fix_data;
    assign o_fix_busy = r_fix_busy;

    a_one_sequence: assert property (@(posedge i_clk) disable iff (!i_res_n)
        !(r_clr_busy && r_fix_busy));
    // delayed fix writes must never land on the idle address
    a_wr_in_field: assert property (@(posedge i_clk) disable iff (!i_res_n)
        o_wr_en |-> o_wr_addr < field_addr_t'(`TETRIS_FIELD_CELLS));

endmodule

//--- source/field_ram.sv
// field cell memory
// one write port, one registered read port for the LCD scan
`timescale 1ns/100ps
`include "tetris_cfg.svh"

module field_ram (
    input   logic                       i_clk,
    input   logic                       i_wr_en,
    input   tetris_pkg::field_addr_t    i_wr_addr,
    input   tetris_pkg::cell_t          i_wr_data,
    input   tetris_pkg::field_addr_t    i_rd_addr,
    output  tetris_pkg::cell_t          o_rd_data
);
    import tetris_pkg::*;

    cell_t  r_mem [`TETRIS_FIELD_CELLS];

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            r_mem[i_wr_addr] <= i_wr_data;
        end
        // idle address reads as empty
        if (i_rd_addr < field_addr_t'(`TETRIS_FIELD_CELLS)) begin
            o_rd_data <= r_mem[i_rd_addr];
        end else begin
            o_rd_data <= EMPTY;
        end
    end

endmodule

//--- source/scan_overlay.sv
// display merge
// lays the active piece over the stored field, aligned to RAM latency
`timescale 1ns/100ps

module scan_overlay (
    input   logic                   i_clk,
    input   logic                   i_res_n,
    input   logic                   i_covered,
    input   tetris_pkg::cell_t      i_kind,
    input   tetris_pkg::cell_t      i_field_data,   // one clock behind the scan
    output  tetris_pkg::cell_t      o_block_data
);
    import tetris_pkg::*;

    logic   r_covered;
    cell_t  r_kind;

    always_ff @(posedge i_clk or negedge i_res_n) begin
        if (!i_res_n) begin
            r_covered <= 1'b0;
        end else begin
            r_covered <= i_covered;
        end
    end

    always_ff @(posedge i_clk) begin
        r_kind <= i_kind;
    end

    assign o_block_data = r_covered ? r_kind : i_field_data;

endmodule

//--- source/tetris_top.sv
// tetris playfield top
// piece control, footprint, field writer, field memory and display merge
`timescale 1ns/100ps

module tetris_top (
    input   logic                       i_clk,
    input   logic                       i_res_n,
    // LCD scan side
    input   tetris_pkg::field_addr_t    i_vram_addr,
    input   tetris_pkg::pos_x_t         i_pos_x,
    input   tetris_pkg::pos_y_t         i_pos_y,
    output  tetris_pkg::cell_t          o_block_data,
    // SNES pad
    input   logic   [14:0]              i_snes_state,
    output  logic                       o_game_reset_pls,
    output  logic                       o_bgm_fixed_pls
);
    import tetris_pkg::*;

    cell_t          w_kind;
    angle_t         w_angle;
    pos_x_t         w_piece_x;
    pos_y_t         w_piece_y;
    logic           w_fix_req;
    logic           w_clear_req;
    logic           w_fix_busy;
    logic           w_fix_done;
    logic           w_covered;
    logic           w_wr_en;
    field_addr_t    w_wr_addr;
    cell_t          w_wr_data;
    cell_t          w_field_data;

    piece_control u_piece_control (
        .i_clk          (i_clk),
        .i_res_n        (i_res_n),
        .i_snes_state   (i_snes_state),
        .i_fix_busy     (w_fix_busy),
        .i_fix_done     (w_fix_done),
        .o_kind         (w_kind),
        .o_angle        (w_angle),
        .o_pos_x        (w_piece_x),
        .o_pos_y        (w_piece_y),
        .o_fix_req      (w_fix_req),
        .o_clear_req    (w_clear_req)
    );

    piece_shape u_piece_shape (
        .i_pos_x        (i_pos_x),
        .i_pos_y        (i_pos_y),
        .i_kind         (w_kind),
        .i_angle        (w_angle),
        .i_piece_x      (w_piece_x),
        .i_piece_y      (w_piece_y),
        .o_covered      (w_covered)
    );

    field_writer u_field_writer (
        .i_clk          (i_clk),
        .i_res_n        (i_res_n),
        .i_fix_req      (w_fix_req),
        .i_clear_req    (w_clear_req),
        .i_vram_addr    (i_vram_addr),
        .i_covered      (w_covered),
        .i_kind         (w_kind),
        .o_wr_en        (w_wr_en),
        .o_wr_addr      (w_wr_addr),
        .o_wr_data      (w_wr_data),
        .o_fix_busy     (w_fix_busy),
        .o_fix_done     (w_fix_done)
    );

    field_ram u_field_ram (
        .i_clk          (i_clk),
        .i_wr_en        (w_wr_en),
        .i_wr_addr      (w_wr_addr),
        .i_wr_data      (w_wr_data),
        .i_rd_addr      (i_vram_addr),
        .o_rd_data      (w_field_data)
    );

    scan_overlay u_scan_overlay (
        .i_clk          (i_clk),
        .i_res_n        (i_res_n),
        .i_covered      (w_covered),
        .i_kind         (w_kind),
        .i_field_data   (w_field_data),
        .o_block_data   (o_block_data)
    );

    assign o_game_reset_pls = w_clear_req;     // SELECT edge
    assign o_bgm_fixed_pls  = w_fix_req;       // fix button edge

endmodule

//--- verification/tb_tetris.sv
// testbench for the tetris playfield
// presses one button per table row, scans two frames, checks the display
`timescale 1ns/100ps
`include "tetris_cfg.svh"

module tb_tetris;
    import tetris_pkg::*;

    localparam int NUM_TESTS   = 14;
    localparam int FRAME_CYC   = `TETRIS_FIELD_CELLS + 20;     // scan plus idle
    localparam int CYCLE_LIMIT = (NUM_TESTS + 2) * 3 * FRAME_CYC;

    logic           i_clk;
    logic           i_res_n;
    field_addr_t    i_vram_addr;
    pos_x_t         i_pos_x;
    pos_y_t         i_pos_y;
    logic   [14:0]  i_snes_state;
    cell_t          o_block_data;
    logic           o_game_reset_pls;
    logic           o_bgm_fixed_pls;

    // ==============================
    // stimulus table
    // ==============================
    string test_name [NUM_TESTS] = '{
        "select_walls", "move_left", "move_right", "move_down",
        "rotate_right_1", "rotate_right_2", "rotate_left", "fix_first",
        "move_down_2", "fix_second", "select_clear", "rotate_left_wrap",
        "rotate_right_wrap", "move_right_2"};
    localparam logic [14:0] TEST_BTN [NUM_TESTS] = '{
        15'(1 << `TETRIS_BTN_SELECT), 15'(1 << `TETRIS_BTN_LEFT),
        15'(1 << `TETRIS_BTN_RIGHT),  15'(1 << `TETRIS_BTN_DOWN),
        15'(1 << `TETRIS_BTN_ROT_R),  15'(1 << `TETRIS_BTN_ROT_R),
        15'(1 << `TETRIS_BTN_ROT_L),  15'(1 << `TETRIS_BTN_FIX),
        15'(1 << `TETRIS_BTN_DOWN),   15'(1 << `TETRIS_BTN_FIX),
        15'(1 << `TETRIS_BTN_SELECT), 15'(1 << `TETRIS_BTN_ROT_L),
        15'(1 << `TETRIS_BTN_ROT_R),  15'(1 << `TETRIS_BTN_RIGHT)};

    // reference model state
    cell_t          shadow [`TETRIS_FIELD_CELLS];
    cell_t          m_kind;
    cell_t          m_next;
    angle_t         m_angle;
    pos_x_t         m_x;
    pos_y_t         m_y;

    int             cycle_cnt    = 0;
    int             reset_pulses = 0;
    int             fix_pulses   = 0;

    tetris_top dut0 (
        .i_clk              (i_clk),
        .i_res_n            (i_res_n),
        .i_vram_addr        (i_vram_addr),
        .i_pos_x            (i_pos_x),
        .i_pos_y            (i_pos_y),
        .o_block_data       (o_block_data),
        .i_snes_state       (i_snes_state),
        .o_game_reset_pls   (o_game_reset_pls),
        .o_bgm_fixed_pls    (o_bgm_fixed_pls)
    );

    initial begin
        i_clk = 1'b0;
        forever begin
            #5 i_clk = ~i_clk;
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    // pulses sampled mid-cycle, well away from the rising edge
    always @(negedge i_clk) begin
        if (o_game_reset_pls) begin
            reset_pulses <= reset_pulses + 1;
        end
        if (o_bgm_fixed_pls) begin
            fix_pulses <= fix_pulses + 1;
        end
    end

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        assert (cycle_cnt < CYCLE_LIMIT) else begin
            stop_on_error($sformatf("timeout, run exceeded %0d cycles", CYCLE_LIMIT));
        end
    end

    // ==============================
    // reference model
    // ==============================
    function automatic cell_t wall_cell(input int x, input int y);
        if (y == `TETRIS_FIELD_H - 1 || x == 0 || x == `TETRIS_FIELD_W - 1) begin
            return WALL;
        end
        if (y == 0 && (x == 1 || x == 2 || x == 9 || x == 10)) begin
            return WALL;        // spout edges in the top row
        end
        return EMPTY;
    endfunction

    function automatic pos_x_t cell_x(input int n);
        return pos_x_t'(m_x + pos_x_t'(PIECE_OFFSETS[int'(m_kind) - int'(I)][m_angle][n][0]));
    endfunction

    function automatic pos_y_t cell_y(input int n);
        return pos_y_t'(m_y + pos_y_t'(PIECE_OFFSETS[int'(m_kind) - int'(I)][m_angle][n][1]));
    endfunction

    function automatic logic model_covers(input pos_x_t x, input pos_y_t y);
        logic   hit;
        hit = 1'b0;
        for (int n = 0; n < 4; n++) begin
            if (x == cell_x(n) && y == cell_y(n)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic update_model(input logic [14:0] btn);
        int     cx;
        int     cy;
        if (btn[`TETRIS_BTN_ROT_R]) begin
            m_angle = m_angle + 2'd1;
        end else if (btn[`TETRIS_BTN_ROT_L]) begin
            m_angle = m_angle - 2'd1;
        end else if (btn[`TETRIS_BTN_DOWN]) begin
            m_y = m_y + 5'd1;
        end else if (btn[`TETRIS_BTN_LEFT]) begin
            m_x = m_x - 4'd1;
        end else if (btn[`TETRIS_BTN_RIGHT]) begin
            m_x = m_x + 4'd1;
        end
        if (btn[`TETRIS_BTN_SELECT]) begin
            for (int a = 0; a < `TETRIS_FIELD_CELLS; a++) begin
                shadow[a] = wall_cell(a % `TETRIS_FIELD_W, a / `TETRIS_FIELD_W);
            end
        end else if (btn[`TETRIS_BTN_FIX]) begin
            for (int n = 0; n < 4; n++) begin
                cx = int'(cell_x(n));
                cy = int'(cell_y(n));
                if (cx < `TETRIS_FIELD_W && cy < `TETRIS_FIELD_H) begin
                    shadow[cy * `TETRIS_FIELD_W + cx] = m_kind;
                end
            end
            // spawn the next kind in I..T order
            m_kind  = m_next;
            m_next  = cell_t'(int'(I) + (int'(m_next) - int'(I) + 1) % 7);
            m_angle = angle_t'(`TETRIS_SPAWN_ANGLE);
            m_x     = pos_x_t'(`TETRIS_SPAWN_X);
            m_y     = pos_y_t'(`TETRIS_SPAWN_Y);
        end
    endtask

    // ==============================
    // scan generator and checks
    // ==============================
    task automatic drive_scan(input int a);
        int     addr;
        addr        = (a < `TETRIS_FIELD_CELLS) ? a : `TETRIS_FIELD_CELLS;
        i_vram_addr = field_addr_t'(addr);
        i_pos_x     = pos_x_t'(addr % `TETRIS_FIELD_W);
        i_pos_y     = pos_y_t'(addr / `TETRIS_FIELD_W);
    endtask

    task automatic check_cell(input int t, input int addr);
        cell_t  exp_code;
        pos_x_t x;
        pos_y_t y;
        x        = pos_x_t'(addr % `TETRIS_FIELD_W);
        y        = pos_y_t'(addr / `TETRIS_FIELD_W);
        exp_code = model_covers(x, y) ? m_kind : shadow[addr];
        assert (o_block_data === exp_code) else begin
            stop_on_error($sformatf("MISMATCH %s addr %0d expected %0d actual %0d",
                test_name[t], addr, exp_code, o_block_data));
        end
    endtask

    // display data for an address is checked one clock later
    task automatic run_frame(input bit check, input int t);
        for (int a = 0; a < FRAME_CYC; a++) begin
            @(negedge i_clk);
            if (check && a > 0 && a <= `TETRIS_FIELD_CELLS) begin
                check_cell(t, a - 1);
            end
            drive_scan(a);
        end
    endtask

    task automatic check_pulses(input int t, input int rst_before, input int fix_before);
        int     exp_rst;
        int     exp_fix;
        exp_rst = int'(TEST_BTN[t][`TETRIS_BTN_SELECT]);
        exp_fix = int'(TEST_BTN[t][`TETRIS_BTN_FIX]);
        assert (reset_pulses - rst_before == exp_rst) else begin
            stop_on_error($sformatf("MISMATCH %s game reset pulses expected %0d actual %0d",
                test_name[t], exp_rst, reset_pulses - rst_before));
        end
        assert (fix_pulses - fix_before == exp_fix) else begin
            stop_on_error($sformatf("MISMATCH %s bgm fixed pulses expected %0d actual %0d",
                test_name[t], exp_fix, fix_pulses - fix_before));
        end
    endtask

    initial begin
        int     rst_before;
        int     fix_before;
        i_res_n      = 1'b0;
        i_snes_state = '0;
        drive_scan(`TETRIS_FIELD_CELLS);        // idle position
        m_kind  = I;
        m_next  = O;
        m_angle = angle_t'(`TETRIS_SPAWN_ANGLE);
        m_x     = pos_x_t'(`TETRIS_SPAWN_X);
        m_y     = pos_y_t'(`TETRIS_SPAWN_Y);
        for (int a = 0; a < `TETRIS_FIELD_CELLS; a++) begin
            shadow[a] = EMPTY;
        end
        repeat (5) @(negedge i_clk);
        i_res_n = 1'b1;

        for (int t = 0; t < NUM_TESTS; t++) begin
            rst_before = reset_pulses;
            fix_before = fix_pulses;
            @(negedge i_clk);
            i_snes_state = TEST_BTN[t];         // press
            @(negedge i_clk);
            i_snes_state = '0;                  // release
            update_model(TEST_BTN[t]);
            run_frame(1'b0, t);                 // writes land in this frame
            run_frame(1'b1, t);
            check_pulses(t, rst_before, fix_before);
        end

        $display("Test passed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+include
source/tetris_pkg.sv
source/piece_control.sv
source/piece_shape.sv
source/field_writer.sv
source/field_ram.sv
source/scan_overlay.sv
source/tetris_top.sv
verification/tb_tetris.sv

//--- Makefile
# Verilator flow for the tetris playfield
TB_TOP = tb_tetris

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sim.f --top-module tetris_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TB_TOP)
	out=$$(./obj_dir/V$(TB_TOP)); echo "$$out"; echo "$$out" | grep -q "^Test passed$$"

clean:
	rm -rf obj_dir
